// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= risc5_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+test
rtl/risc5_pkg.sv
rtl/risc5_alu.sv
rtl/risc5_regfile.sv
rtl/risc5_ctrl.sv
rtl/risc5_core.sv
test/risc5_tb.sv

// File: rtl/risc5_alu.sv
// --------------------------------------
// purely combinational with the shift count in op2[4:0]
// --------------------------------------
`timescale 1ns/1ns

module risc5_alu import risc5_pkg::*; (
  input  word_t    op1,
  input  word_t    op2,
  input  alu_fnc_t fnc,
  output word_t    res
);

  logic [4:0] sh;
  logic       sgn;
  word_t      lsl_s0, lsl_s1, lsl_res;
  word_t      asr_s0, asr_s1, asr_res;
  word_t      ror_s0, ror_s1, ror_res;

  assign sh  = op2[4:0];
  assign sgn = op1[31];

  // shift left in stages of 1..3, 4..12 and 16
  always_comb begin
    case (sh[1:0])
      2'd0: lsl_s0 = op1;
      2'd1: lsl_s0 = {op1[30:0], 1'b0};
      2'd2: lsl_s0 = {op1[29:0], 2'b0};
      default: lsl_s0 = {op1[28:0], 3'b0};
    endcase
    case (sh[3:2])
      2'd0: lsl_s1 = lsl_s0;
      2'd1: lsl_s1 = {lsl_s0[27:0], 4'b0};
      2'd2: lsl_s1 = {lsl_s0[23:0], 8'b0};
      default: lsl_s1 = {lsl_s0[19:0], 12'b0};
    endcase
    lsl_res = sh[4] ? {lsl_s1[15:0], 16'b0} : lsl_s1;
  end

  // arithmetic shift right
  always_comb begin
    case (sh[1:0])
      2'd0: asr_s0 = op1;
      2'd1: asr_s0 = {sgn, op1[31:1]};
      2'd2: asr_s0 = {{2{sgn}}, op1[31:2]};
      default: asr_s0 = {{3{sgn}}, op1[31:3]};
    endcase
    case (sh[3:2])
      2'd0: asr_s1 = asr_s0;
      2'd1: asr_s1 = {{4{sgn}}, asr_s0[31:4]};
      2'd2: asr_s1 = {{8{sgn}}, asr_s0[31:8]};
      default: asr_s1 = {{12{sgn}}, asr_s0[31:12]};
    endcase
    asr_res = sh[4] ? {{16{sgn}}, asr_s1[31:16]} : asr_s1;
  end

  // rotate right
  always_comb begin
    case (sh[1:0])
      2'd0: ror_s0 = op1;
      2'd1: ror_s0 = {op1[0], op1[31:1]};
      2'd2: ror_s0 = {op1[1:0], op1[31:2]};
      default: ror_s0 = {op1[2:0], op1[31:3]};
    endcase
    case (sh[3:2])
      2'd0: ror_s1 = ror_s0;
      2'd1: ror_s1 = {ror_s0[3:0], ror_s0[31:4]};
      2'd2: ror_s1 = {ror_s0[7:0], ror_s0[31:8]};
      default: ror_s1 = {ror_s0[11:0], ror_s0[31:12]};
    endcase
    ror_res = sh[4] ? {ror_s1[15:0], ror_s1[31:16]} : ror_s1;
  end

  always_comb begin
    case (fnc)
      ALU_MOV: res = op2;
      ALU_LSL: res = lsl_res;
      ALU_ASR: res = asr_res;
      ALU_ROR: res = ror_res;
      ALU_AND: res = op1 & op2;
      ALU_ANN: res = op1 & ~op2;
      ALU_IOR: res = op1 | op2;
      ALU_XOR: res = op1 ^ op2;
      ALU_ADD: res = op1 + op2;
      ALU_SUB: res = op1 - op2;
      default: res = '0;  // undefined codes
    endcase
  end

endmodule

// File: rtl/risc5_core.sv
// --------------------------------------
// one bus request at a time and no branch execution
// RESET_VECTOR must be word aligned
// --------------------------------------
`timescale 1ns/1ns

module risc5_core import risc5_pkg::*; #(
  parameter addr_t RESET_VECTOR = RESET_ADDR
) (
  input  logic  clk,
  input  logic  rst,
  output logic  bus_stb,
  output logic  bus_we,
  output logic  bus_ben,
  output addr_t bus_addr,
  output word_t bus_dout,
  input  word_t bus_din,
  input  logic  bus_ack,
  output logic  halt
);

  pc_src_t  pc_src;
  a2_src_t  a2_src;
  op2_src_t op2_src;
  logic     pc_we, ir_we, addr_sel, reg_we, wb_load, op1_reg, alu_add;

  addr_t    pc, pc_next, mar;
  word_t    ir, alu_op1, alu_op2, alu_res, alu_out;
  word_t    rd1, rd2, wd, ld_data;
  alu_fnc_t alu_fnc;
  reg_idx_t ra2;

  // --------------------------------------
  // pc and instruction register
  // --------------------------------------
  always_comb begin
    case (pc_src)
      PC_RESET:  pc_next = RESET_VECTOR;
      default:   pc_next = alu_res[ADDR_W-1:0];  // pc + 4
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_we) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ir_we) begin
      ir <= bus_din;
    end
  end

  // --------------------------------------
  // register file and operands
  // --------------------------------------
  always_comb begin
    case (a2_src)
      A2_A:    ra2 = ir[A_MSB:A_LSB];
      default: ra2 = ir[C_MSB:C_LSB];
    endcase
  end

  assign wd = wb_load ? ld_data : alu_out;

  risc5_regfile risc5_regfile_inst (
    .clk (clk),
    .rst (rst),
    .ra1 (ir[B_MSB:B_LSB]),
    .rd1 (rd1),
    .ra2 (ra2),
    .rd2 (rd2),
    .we  (reg_we),
    .wd  (wd)
  );

  assign alu_op1 = op1_reg ? rd1 : {8'h00, pc};

  always_comb begin
    case (op2_src)
      OP2_REG: alu_op2 = rd2;
      OP2_IMM: alu_op2 = {{16{ir[V_BIT]}}, ir[IMM_MSB:0]};  // v fill
      OP2_OFF: alu_op2 = {{12{ir[OFF_MSB]}}, ir[OFF_MSB:0]};
      default: alu_op2 = 32'd4;
    endcase
  end

  assign alu_fnc = alu_add ? ALU_ADD : alu_fnc_t'(ir[OP_MSB:OP_LSB]);

  risc5_alu risc5_alu_inst (
    .op1 (alu_op1),
    .op2 (alu_op2),
    .fnc (alu_fnc),
    .res (alu_res)
  );

  always_ff @(posedge clk) begin
    alu_out <= alu_res;
  end

  // --------------------------------------
  // memory access
  // --------------------------------------
  always_ff @(posedge clk) begin
    if (!addr_sel) begin
      mar <= alu_res[ADDR_W-1:0];  // frozen during the access
    end
  end

  always_ff @(posedge clk) begin
    if (addr_sel && bus_ack) begin
      if (ir[V_BIT]) begin
        ld_data <= {24'h0, bus_din[mar[1:0]*8 +: 8]};  // little-endian lane
      end else begin
        ld_data <= bus_din;
      end
    end
  end

  assign bus_addr = addr_sel ? mar : pc;
  assign bus_ben  = addr_sel & ir[V_BIT];
  assign bus_dout = ir[V_BIT] ? {4{rd2[7:0]}} : rd2;

  risc5_ctrl risc5_ctrl_inst (
    .clk      (clk),
    .rst      (rst),
    .fmt      (fmt_t'(ir[PQ_MSB:PQ_LSB])),
    .store    (ir[U_BIT]),
    .bus_ack  (bus_ack),
    .pc_src   (pc_src),
    .pc_we    (pc_we),
    .ir_we    (ir_we),
    .addr_sel (addr_sel),
    .bus_stb  (bus_stb),
    .bus_we   (bus_we),
    .a2_src   (a2_src),
    .reg_we   (reg_we),
    .wb_load  (wb_load),
    .op1_reg  (op1_reg),
    .op2_src  (op2_src),
    .alu_add  (alu_add),
    .halt     (halt)
  );

endmodule

// File: rtl/risc5_ctrl.sv
// --------------------------------------
// outputs decode from state, bus_ack, fmt, store
// branches are not executed, they halt the core
// --------------------------------------
`timescale 1ns/1ns

module risc5_ctrl import risc5_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  fmt_t     fmt,
  input  logic     store,
  input  logic     bus_ack,
  output pc_src_t  pc_src,
  output logic     pc_we,
  output logic     ir_we,
  output logic     addr_sel,
  output logic     bus_stb,
  output logic     bus_we,
  output a2_src_t  a2_src,
  output logic     reg_we,
  output logic     wb_load,
  output logic     op1_reg,
  output op2_src_t op2_src,
  output logic     alu_add,
  output logic     halt
);

  typedef enum logic [3:0] {
    ST_RESET   = 4'd0,
    ST_FETCH   = 4'd1,
    ST_DECODE  = 4'd2,
    ST_EXEC    = 4'd3,
    ST_WB      = 4'd4,
    ST_ADDR    = 4'd5,
    ST_MEM     = 4'd6,
    ST_LOAD_WB = 4'd7,
    ST_HALT    = 4'd8
  } state_t;

  state_t state, state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_RESET;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------
  // next state and control decode
  // --------------------------------------
  always_comb begin
    state_next = state;
    pc_src     = PC_NEXT;
    pc_we      = 1'b0;
    ir_we      = 1'b0;
    addr_sel   = 1'b0;
    bus_stb    = 1'b0;
    bus_we     = 1'b0;
    a2_src     = A2_C;
    reg_we     = 1'b0;
    wb_load    = 1'b0;
    op1_reg    = 1'b0;
    op2_src    = OP2_FOUR;
    alu_add    = 1'b0;
    halt       = 1'b0;
    case (state)
      ST_RESET: begin
        pc_src     = PC_RESET;
        pc_we      = 1'b1;  // load reset vector
        state_next = ST_FETCH;
      end
      ST_FETCH: begin
        bus_stb = 1'b1;
        op2_src = OP2_FOUR;  // pc + 4
        alu_add = 1'b1;
        pc_we   = bus_ack;
        ir_we   = bus_ack;
        if (bus_ack) begin
          state_next = ST_DECODE;
        end
      end
      ST_DECODE: begin
        // port 2 fetches reg a for stores, reg c otherwise
        a2_src = (fmt == FMT_MEM) ? A2_A : A2_C;
        case (fmt)
          FMT_REG, FMT_IMM: state_next = ST_EXEC;
          FMT_MEM: state_next = ST_ADDR;
          default: state_next = ST_HALT;
        endcase
      end
      ST_EXEC: begin
        op1_reg    = 1'b1;
        op2_src    = (fmt == FMT_REG) ? OP2_REG : OP2_IMM;
        state_next = ST_WB;
      end
      ST_WB: begin
        a2_src     = A2_A;
        reg_we     = 1'b1;
        state_next = ST_FETCH;
      end
      ST_ADDR: begin
        a2_src     = A2_A;  // keep store data on rd2
        op1_reg    = 1'b1;
        op2_src    = OP2_OFF;
        alu_add    = 1'b1;
        state_next = ST_MEM;
      end
      ST_MEM: begin
        a2_src   = A2_A;
        addr_sel = 1'b1;
        bus_stb  = 1'b1;
        bus_we   = store;
        if (bus_ack) begin
          state_next = store ? ST_FETCH : ST_LOAD_WB;
        end
      end
      ST_LOAD_WB: begin
        a2_src     = A2_A;
        reg_we     = 1'b1;
        wb_load    = 1'b1;
        state_next = ST_FETCH;
      end
      ST_HALT: begin
        halt = 1'b1;  // held until rst
      end
      default: begin
        state_next = ST_RESET;  // unused encodings
      end
    endcase
  end

endmodule

// File: rtl/risc5_pkg.sv
// --------------------------------------
// shared types and constants of the core
// enum codes follow the instruction fields
// --------------------------------------
package risc5_pkg;

  localparam int WORD_W   = 32;
  localparam int ADDR_W   = 24;
  localparam int REG_W    = 4;
  localparam int NUM_REGS = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [REG_W-1:0]  reg_idx_t;

  // instruction field positions
  localparam int PQ_MSB  = 31;
  localparam int PQ_LSB  = 30;
  localparam int U_BIT   = 29;
  localparam int V_BIT   = 28;
  localparam int A_MSB   = 27;
  localparam int A_LSB   = 24;
  localparam int B_MSB   = 23;
  localparam int B_LSB   = 20;
  localparam int OP_MSB  = 19;
  localparam int OP_LSB  = 16;
  localparam int C_MSB   = 3;
  localparam int C_LSB   = 0;
  localparam int IMM_MSB = 15;
  localparam int OFF_MSB = 19;

  typedef enum logic [3:0] {
    ALU_MOV = 4'd0, ALU_LSL = 4'd1, ALU_ASR = 4'd2, ALU_ROR = 4'd3,
    ALU_AND = 4'd4, ALU_ANN = 4'd5, ALU_IOR = 4'd6, ALU_XOR = 4'd7,
    ALU_ADD = 4'd8, ALU_SUB = 4'd9
  } alu_fnc_t;  // 10..15 give zero

  typedef enum logic [1:0] {
    FMT_REG = 2'd0, FMT_IMM = 2'd1, FMT_MEM = 2'd2, FMT_BR = 2'd3
  } fmt_t;

  typedef enum logic [1:0] {PC_RESET = 2'd0, PC_NEXT = 2'd1, PC_BRANCH = 2'd2} pc_src_t;
  typedef enum logic [1:0] {A2_C = 2'd0, A2_A = 2'd1, A2_LINK = 2'd2} a2_src_t;
  typedef enum logic [1:0] {
    OP2_FOUR = 2'd0, OP2_REG = 2'd1, OP2_IMM = 2'd2, OP2_OFF = 2'd3
  } op2_src_t;

  localparam addr_t RESET_ADDR = 24'hFFE000;  // boot rom base

endpackage

// File: rtl/risc5_regfile.sv
// --------------------------------------
// registered reads with one cycle of latency
// port 2 writes to the address it reads
// --------------------------------------
`timescale 1ns/1ns

module risc5_regfile import risc5_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t ra1,
  output word_t    rd1,
  input  reg_idx_t ra2,
  output word_t    rd2,
  input  logic     we,
  input  word_t    wd
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      rd1 <= '0;
      rd2 <= '0;
    end else begin
      rd1 <= regs[ra1];
      rd2 <= regs[ra2];  // old value while writing
      if (we) begin
        regs[ra2] <= wd;
      end
    end
  end

endmodule

// File: test/risc5_model.svh
// ----------------------------------------
// instruction set model, program generator, compare tasks
// included inside risc5_tb and shares its counters and seed
// ----------------------------------------

  localparam int MAX_PROG = 512;

  word_t  prog [MAX_PROG];
  int     prog_len;
  word_t  m_regs [16];
  integer seed;
  int     errors;

  // expected data access armed when a format 2 fetch is acknowledged
  logic   data_pending;
  logic   halt_expected;
  addr_t  exp_addr;
  logic   exp_we, exp_ben;
  word_t  exp_dout, load_data;

  function automatic int pick_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic word_t alu_ref(input alu_fnc_t fnc, input word_t x, input word_t y);
    int s;
    s = int'(y[4:0]);  // shift count
    case (fnc)
      ALU_MOV: return y;
      ALU_LSL: return x << s;
      ALU_ASR: return word_t'($signed(x) >>> s);
      ALU_ROR: return (x >> s) | (x << (32 - s));
      ALU_AND: return x & y;
      ALU_ANN: return x & ~y;
      ALU_IOR: return x | y;
      ALU_XOR: return x ^ y;
      ALU_ADD: return x + y;
      ALU_SUB: return x - y;
      default: return '0;
    endcase
  endfunction

  // ----------------------------------------
  // program generator
  // ----------------------------------------
  function automatic word_t make_alu_instr();
    word_t ins;
    ins = word_t'($random(seed));
    ins[31:30] = 2'(pick_below(2));  // format 0 or 1
    ins[29] = 1'b0;
    ins[19:16] = 4'(pick_below(10));
    return ins;
  endfunction

  function automatic word_t make_mem_instr();
    word_t ins;
    ins = word_t'($random(seed));  // random u, v, a, b and offset
    ins[31:30] = 2'b10;
    return ins;
  endfunction

  task automatic build_program();
    int n;
    int i;
    int r;
    n = 0;
    for (i = 0; i < 200; i++) begin
      if (pick_below(4) == 0) begin
        prog[n] = make_mem_instr();
        n++;
      end
      prog[n] = make_alu_instr();
      n++;
    end
    for (r = 0; r < 16; r++) begin
      prog[n] = {2'b10, 1'b1, 1'b0, 4'(r), 4'd0, 20'(r * 4)};  // word store of r
      n++;
    end
    prog[n] = 32'hC000_0000;  // branch
    prog_len = n + 1;
  endtask

  // ----------------------------------------
  // model step run at each fetch acknowledge
  // ----------------------------------------
  task automatic model_step(input word_t ins);
    reg_idx_t   a, b, c;
    word_t      sum;
    logic [7:0] byte_val;
    a = ins[27:24];
    b = ins[23:20];
    c = ins[3:0];
    case (ins[31:30])
      2'd0: m_regs[a] = alu_ref(alu_fnc_t'(ins[19:16]), m_regs[b], m_regs[c]);
      2'd1: m_regs[a] = alu_ref(alu_fnc_t'(ins[19:16]), m_regs[b],
                                {{16{ins[28]}}, ins[15:0]});  // v fill
      2'd2: begin
        sum      = m_regs[b] + {{12{ins[19]}}, ins[19:0]};
        exp_addr = sum[23:0];
        exp_we   = ins[29];
        exp_ben  = ins[28];
        exp_dout = ins[28] ? {4{m_regs[a][7:0]}} : m_regs[a];
        if (!ins[29]) begin
          load_data = word_t'($random(seed));
          byte_val  = 8'(load_data >> (8 * int'(exp_addr[1:0])));  // little endian lane
          m_regs[a] = ins[28] ? {24'h0, byte_val} : load_data;
        end
        data_pending = 1'b1;
      end
      default: halt_expected = 1'b1;
    endcase
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s: expected %h, got %h", name, expected, actual);
    end
  endtask

// File: test/risc5_tb.sv
// ----------------------------------------
// random program from seed 93 checked against the model
// memory acks after 0 to 3 cycles and loads give random data
// ----------------------------------------
`timescale 1ns/1ns

module risc5_tb import risc5_pkg::*; ();

  localparam addr_t RESET_VEC = RESET_ADDR;

  logic  clk, rst;
  logic  bus_stb, bus_we, bus_ben, bus_ack, halt;
  addr_t bus_addr;
  word_t bus_dout, bus_din;
  int    fetch_cnt;

  `include "risc5_model.svh"

  risc5_core #(.RESET_VECTOR(RESET_VEC)) risc5_core_inst (
    .clk      (clk),
    .rst      (rst),
    .bus_stb  (bus_stb),
    .bus_we   (bus_we),
    .bus_ben  (bus_ben),
    .bus_addr (bus_addr),
    .bus_dout (bus_dout),
    .bus_din  (bus_din),
    .bus_ack  (bus_ack),
    .halt     (halt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // memory responder
  // ----------------------------------------
  task automatic stretch_access();
    int dly;
    dly = pick_below(4);
    repeat (dly) begin
      @(negedge clk);
      if (bus_stb !== 1'b1) begin
        errors++;
        $display("bus_stb dropped before the access was acknowledged");
      end
    end
  endtask

  task automatic serve_fetch();
    addr_t exp_pc;
    word_t ins;
    exp_pc = RESET_VEC + addr_t'(4 * fetch_cnt);
    check_addr("bus_addr", exp_pc, bus_addr);
    check_bit("bus_we", 1'b0, bus_we);
    check_bit("bus_ben", 1'b0, bus_ben);
    check_bit("halt", 1'b0, halt);
    ins = (fetch_cnt < prog_len) ? prog[fetch_cnt] : 32'hC000_0000;
    stretch_access();
    check_addr("bus_addr", exp_pc, bus_addr);  // held during the wait
    bus_din = ins;
    bus_ack = 1'b1;
    model_step(ins);
    fetch_cnt++;
  endtask

  task automatic serve_data();
    addr_t mask;
    stretch_access();
    mask = exp_ben ? 24'hFFFFFF : 24'hFFFFFC;  // words ignore low bits
    check_addr("bus_addr", exp_addr & mask, bus_addr & mask);
    check_bit("bus_we", exp_we, bus_we);
    check_bit("bus_ben", exp_ben, bus_ben);
    if (exp_we) begin
      check_word("bus_dout", exp_dout, bus_dout);
    end
    bus_din      = load_data;
    bus_ack      = 1'b1;
    data_pending = 1'b0;
  endtask

  initial begin
    int i;
    bus_ack       = 1'b0;
    bus_din       = '0;
    seed          = 93;
    fetch_cnt     = 0;
    data_pending  = 1'b0;
    halt_expected = 1'b0;
    load_data     = '0;
    for (i = 0; i < 16; i++) begin
      m_regs[i] = '0;  // core clears its registers on reset
    end
    build_program();
    forever begin
      @(negedge clk);
      bus_ack = 1'b0;
      if (bus_stb === 1'b1) begin
        if (data_pending) begin
          serve_data();
        end else begin
          serve_fetch();
        end
      end
    end
  end

  // ----------------------------------------
  // halt and quiet bus after the branch
  // ----------------------------------------
  task automatic watch_halt();
    int stb_seen;
    stb_seen = 0;
    repeat (2) @(negedge clk);  // decode then halt state
    check_bit("halt", 1'b1, halt);
    repeat (50) begin
      @(negedge clk);
      check_bit("halt", 1'b1, halt);  // held until rst
      if (bus_stb !== 1'b0) begin
        stb_seen++;
      end
    end
    if (stb_seen != 0) begin
      errors++;
      $display("bus_stb was raised %0d times after the core halted", stb_seen);
    end
  endtask

  initial begin
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    wait (halt_expected == 1'b1);
    watch_halt();
    $display("errors: %0d, fetches: %0d of %0d", errors, fetch_cnt, prog_len);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // about 12 cycles per instruction at most
  initial begin
    wait (prog_len > 0);
    #((prog_len * 12 + 100) * 100);
    $display("watchdog expired after %0d fetches, the core stopped making progress",
             fetch_cnt);
    $display("Test failed");
    $finish;
  end

endmodule
